//--- rtl/corePkg.sv
`default_nettype none

package corePkg;

    // Datapath and address width
    localparam int xlen = 32;

    // First fetch address after reset
    localparam logic [xlen-1:0] resetPc = 32'h0000_0000;

    // Major opcodes of the supported RV32I subset
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opLui    = 7'b0110111;
    localparam logic [6:0] opAuipc  = 7'b0010111;

    // Result source select codes
    localparam logic [1:0] resAlu = 2'b00;
    localparam logic [1:0] resMem = 2'b01;
    localparam logic [1:0] resPc4 = 2'b10;

    // Immediate formats
    typedef enum logic [2:0] {
        immI,
        immS,
        immB,
        immU,
        immJ
    } immSrcT;

    // Fetch to decode packet, 130 bits
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] instr;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pcPlus4;
        logic [xlen-1:0] predTarget;
        logic            predTaken;
    } fetchPktT;

    // Control levels, 9 bits
    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        logic       aluSrcImm;
        logic       branch;
        logic       jump;
        logic       jumpReg;
        logic [1:0] resultSrc;
        logic       illegal;
    } ctrlT;

    // Decode to execute packet
    typedef struct packed {
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] pcPlus4;
        logic [xlen-1:0] predTarget;
        logic            predTaken;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [6:0]      op;
        logic [2:0]      funct3;
        logic            funct7b5;
        logic [xlen-1:0] imm;
        ctrlT            ctrl;
    } decodePktT;

endpackage

`default_nettype wire

//--- rtl/pipeReg.sv
`timescale 1ns/1ns
`default_nettype none

module pipeReg #(
    // Payload carried across the stage boundary
    parameter type payloadT = logic [31:0]
) (
    // Clock and reset
    input  logic    clk,
    input  logic    rstN,

    // Stage control
    input  logic    en,
    input  logic    clear,

    // Payload
    input  payloadT d,
    output payloadT q
);

    // Clear beats enable, so a flush wins over a stall
    always_ff @(posedge clk) begin
        if (!rstN || clear) begin
            // All zeros, valid bit included
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

//--- rtl/immExtend.sv
`timescale 1ns/1ns
`default_nettype none

module immExtend (
    // Upper instruction bits, opcode not needed
    input  logic [31:7]     instrBits,

    // Format select from control decode
    input  corePkg::immSrcT immSrc,

    // Sign-extended immediate
    output logic [31:0]     imm
);

    logic signBit;

    // Sign always comes from bit 31
    assign signBit = instrBits[31];

    always_comb begin
        case (immSrc)
            // Loads, JALR, register-immediate ops
            corePkg::immI: begin
                imm = {{20{signBit}}, instrBits[31:20]};
            end
            // Stores, split field
            corePkg::immS: begin
                imm = {{20{signBit}}, instrBits[31:25], instrBits[11:7]};
            end
            // Branches, halfword offset
            corePkg::immB: begin
                imm = {{20{signBit}}, instrBits[7], instrBits[30:25],
                       instrBits[11:8], 1'b0};
            end
            // LUI and AUIPC, low twelve bits zero
            corePkg::immU: begin
                imm = {instrBits[31:12], 12'b0};
            end
            // JAL, halfword offset
            corePkg::immJ: begin
                imm = {{12{signBit}}, instrBits[19:12], instrBits[20],
                       instrBits[30:21], 1'b0};
            end
            // Unused encodings
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/controlDecode.sv
`timescale 1ns/1ns
`default_nettype none

module controlDecode (
    // Major opcode
    input  logic [6:0]      op,

    // Decoded control levels
    output corePkg::ctrlT   ctrl,
    output corePkg::immSrcT immSrc
);

    always_comb begin
        // Defaults, no writes and ALU result
        ctrl           = '0;
        ctrl.resultSrc = corePkg::resAlu;
        immSrc         = corePkg::immI;

        case (op)
            corePkg::opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.resultSrc = corePkg::resMem;
            end
            corePkg::opStore: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                immSrc         = corePkg::immS;
            end
            corePkg::opBranch: begin
                ctrl.branch = 1'b1;
                immSrc      = corePkg::immB;
            end
            corePkg::opJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.resultSrc = corePkg::resPc4;
                immSrc         = corePkg::immJ;
            end
            // Target from rs1 plus I immediate
            corePkg::opJalr: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.jumpReg   = 1'b1;
                ctrl.resultSrc = corePkg::resPc4;
            end
            corePkg::opOpImm: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            // Register-register, immediate unused
            corePkg::opOp: begin
                ctrl.regWrite = 1'b1;
            end
            corePkg::opLui, corePkg::opAuipc: begin
                ctrl.regWrite = 1'b1;
                immSrc        = corePkg::immU;
            end
            // Unknown, CSR and system opcodes
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/fetchStage.sv
`timescale 1ns/1ns
`default_nettype none

module fetchStage (
    // Clock and reset
    input  logic              clk,
    input  logic              rstN,

    // Pipeline control
    input  logic              stallF,
    input  logic              redirectValid,
    input  logic [31:0]       redirectPc,

    // Instruction memory, answers in the same cycle
    input  logic [31:0]       instrData,
    output logic [31:0]       instrAddr,

    // Packet to decode
    output corePkg::fetchPktT fetchPkt
);

    logic [corePkg::xlen-1:0] pc;
    logic [corePkg::xlen-1:0] pcPlus4;
    logic [corePkg::xlen-1:0] immJ;
    logic [corePkg::xlen-1:0] immB;
    logic [corePkg::xlen-1:0] predTarget;
    logic                     predTaken;
    logic [6:0]               opF;

    assign opF     = instrData[6:0];
    assign pcPlus4 = pc + 32'd4;

    // J immediate, bit 0 always zero
    assign immJ = {{12{instrData[31]}}, instrData[19:12], instrData[20],
                   instrData[30:21], 1'b0};

    // B immediate, bit 0 always zero
    assign immB = {{20{instrData[31]}}, instrData[7], instrData[30:25],
                   instrData[11:8], 1'b0};

    // Static prediction
    // JAL always taken, branch taken only when its offset is negative
    always_comb begin
        predTaken  = 1'b0;
        predTarget = pcPlus4;
        if (opF == corePkg::opJal) begin
            predTaken  = 1'b1;
            predTarget = pc + immJ;
        end else if (opF == corePkg::opBranch) begin
            // Sign bit of the offset
            predTaken  = instrData[31];
            predTarget = instrData[31] ? (pc + immB) : pcPlus4;
        end
    end

    // PC register
    // Redirect first, then stall, then prediction
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= corePkg::resetPc;
        end else if (redirectValid) begin
            pc <= redirectPc;
        end else if (!stallF) begin
            pc <= predTaken ? predTarget : pcPlus4;
        end
    end

    assign instrAddr = pc;

    // Valid whenever out of reset
    assign fetchPkt.valid      = rstN;
    assign fetchPkt.instr      = instrData;
    assign fetchPkt.pc         = pc;
    assign fetchPkt.pcPlus4    = pcPlus4;
    assign fetchPkt.predTarget = predTarget;
    assign fetchPkt.predTaken  = predTaken;

endmodule

`default_nettype wire

//--- rtl/decodeStage.sv
`timescale 1ns/1ns
`default_nettype none

module decodeStage (
    // Clock and reset
    input  logic               clk,
    input  logic               rstN,

    // Pipeline control
    input  logic               stallD,
    input  logic               flushD,

    // Packet from fetch
    input  corePkg::fetchPktT  fetchPkt,

    // Decoded packet, combinational from the register
    output corePkg::decodePktT decodePkt
);

    corePkg::fetchPktT fetchPktD;
    corePkg::ctrlT     ctrlD;
    corePkg::immSrcT   immSrcD;
    logic [31:0]       instrD;
    logic [31:0]       immD;

    // Fetch/decode boundary register
    pipeReg #(
        .payloadT (corePkg::fetchPktT)
    ) uFdReg (
        .clk   (clk),
        .rstN  (rstN),
        .en    (~stallD),
        .clear (flushD),
        .d     (fetchPkt),
        .q     (fetchPktD)
    );

    assign instrD = fetchPktD.instr;

    // Opcode to control levels
    controlDecode uCtrl (
        .op     (instrD[6:0]),
        .ctrl   (ctrlD),
        .immSrc (immSrcD)
    );

    // Immediate for the decoded format
    immExtend uImm (
        .instrBits (instrD[31:7]),
        .immSrc    (immSrcD),
        .imm       (immD)
    );

    // Pass-through fields
    assign decodePkt.valid      = fetchPktD.valid;
    assign decodePkt.pc         = fetchPktD.pc;
    assign decodePkt.pcPlus4    = fetchPktD.pcPlus4;
    assign decodePkt.predTarget = fetchPktD.predTarget;
    assign decodePkt.predTaken  = fetchPktD.predTaken;

    // Register and function fields
    assign decodePkt.rd       = instrD[11:7];
    assign decodePkt.rs1      = instrD[19:15];
    assign decodePkt.rs2      = instrD[24:20];
    assign decodePkt.op       = instrD[6:0];
    assign decodePkt.funct3   = instrD[14:12];
    assign decodePkt.funct7b5 = instrD[30];

    // Decoded results
    assign decodePkt.imm  = immD;
    assign decodePkt.ctrl = ctrlD;

endmodule

`default_nettype wire

//--- rtl/frontEnd.sv
`timescale 1ns/1ns
`default_nettype none

module frontEnd (
    // Clock and reset
    input  logic               clk,
    input  logic               rstN,

    // Stall and flush levels
    input  logic               stallF,
    input  logic               stallD,
    input  logic               flushD,
    input  logic               flushE,

    // Mispredict redirect from execute
    input  logic               redirectValid,
    input  logic [31:0]        redirectPc,

    // Instruction memory
    input  logic [31:0]        instrData,
    output logic [31:0]        instrAddr,

    // Packet into execute
    output corePkg::decodePktT exPkt
);

    corePkg::fetchPktT  fetchPkt;
    corePkg::decodePktT decodePkt;

    // PC and static prediction
    fetchStage uFetch (
        .clk           (clk),
        .rstN          (rstN),
        .stallF        (stallF),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .instrData     (instrData),
        .instrAddr     (instrAddr),
        .fetchPkt      (fetchPkt)
    );

    // Fetch/decode register and decode logic
    decodeStage uDecode (
        .clk       (clk),
        .rstN      (rstN),
        .stallD    (stallD),
        .flushD    (flushD),
        .fetchPkt  (fetchPkt),
        .decodePkt (decodePkt)
    );

    // Decode/execute register, never stalls
    pipeReg #(
        .payloadT (corePkg::decodePktT)
    ) uDeReg (
        .clk   (clk),
        .rstN  (rstN),
        .en    (1'b1),
        .clear (flushE),
        .d     (decodePkt),
        .q     (exPkt)
    );

endmodule

`default_nettype wire

//--- verif/clockGen.sv
`timescale 1ns/1ns
`default_nettype none

module clockGen (
    output logic clk,
    output logic rstN
);

    // 8 ns period
    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Reset held low for 8 rising edges
    initial begin
        rstN = 1'b0;
        repeat (8) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

//--- verif/frontEnd_props.sv
`timescale 1ns/1ns
`default_nettype none

module frontEnd_props (
    input logic               clk,
    input logic               rstN,
    input logic               stallF,
    input logic               redirectValid,
    input logic [31:0]        redirectPc,
    input logic [31:0]        instrAddr,
    input corePkg::decodePktT exPkt
);

    // Number of failed assertions
    int failCount = 0;

    // Redirect lands on the requested address one edge later
    redirectTakesPc: assert property (@(posedge clk) disable iff (!rstN)
        redirectValid |=> instrAddr == $past(redirectPc))
        else begin
            failCount++;
            $error("Error at %0t: PC did not follow the redirect", $time);
        end

    // Stalled fetch keeps its PC unless redirected
    stallHoldsPc: assert property (@(posedge clk) disable iff (!rstN)
        stallF && !redirectValid |=> instrAddr == $past(instrAddr))
        else begin
            failCount++;
            $error("Error at %0t: PC moved during a fetch stall", $time);
        end

    // Reset empties execute and restarts fetch
    resetClearsEx: assert property (@(posedge clk)
        !rstN |=> !exPkt.valid && instrAddr == corePkg::resetPc)
        else begin
            failCount++;
            $error("Error at %0t: reset left exPkt valid or PC off", $time);
        end

endmodule

bind frontEnd frontEnd_props uProps (
    .clk           (clk),
    .rstN          (rstN),
    .stallF        (stallF),
    .redirectValid (redirectValid),
    .redirectPc    (redirectPc),
    .instrAddr     (instrAddr),
    .exPkt         (exPkt)
);

`default_nettype wire

//--- verif/frontEndTb.sv
`timescale 1ns/1ns
`default_nettype none

module frontEndTb;

    logic               clk;
    logic               rstN;
    logic               stallF;
    logic               stallD;
    logic               flushD;
    logic               flushE;
    logic               redirectValid;
    logic [31:0]        redirectPc;
    logic [31:0]        instrData;
    logic [31:0]        instrAddr;
    corePkg::decodePktT exPkt;

    // Instruction memory, 256 words
    logic [31:0] instrMem [256];

    // Shadow pipeline: fetch PC, decode slot, execute slot
    logic [31:0] modelPc;
    logic [31:0] modelDPc;
    logic [31:0] modelEPc;
    logic        modelDValid;
    logic        modelEValid;

    int errCount;
    int failedTests;
    int cycleCount;
    int cycleLimit;

    clockGen uClock (
        .clk  (clk),
        .rstN (rstN)
    );

    frontEnd i_frontEnd (
        .clk           (clk),
        .rstN          (rstN),
        .stallF        (stallF),
        .stallD        (stallD),
        .flushD        (flushD),
        .flushE        (flushE),
        .redirectValid (redirectValid),
        .redirectPc    (redirectPc),
        .instrData     (instrData),
        .instrAddr     (instrAddr),
        .exPkt         (exPkt)
    );

    // Memory answers in the same cycle, address wraps at 1 KiB
    assign instrData = instrMem[instrAddr[9:2]];

    // Local checks plus the bound protocol checks
    function automatic int errorTotal();
        return errCount + i_frontEnd.uProps.failCount;
    endfunction

    function automatic logic [31:0] wordAt(input logic [31:0] addr);
        return instrMem[addr[9:2]];
    endfunction

    // rd, rs1, rs2, funct3, funct7 bit 5, opcode
    function automatic logic [25:0] fieldsOf(input logic [31:0] w);
        return {w[11:7], w[19:15], w[24:20], w[14:12], w[30], w[6:0]};
    endfunction

    // Immediate picked by opcode, I format for everything else
    function automatic logic [31:0] immOf(input logic [31:0] w);
        case (w[6:0])
            corePkg::opStore:  return {{20{w[31]}}, w[31:25], w[11:7]};
            corePkg::opBranch: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            corePkg::opLui:    return {w[31:12], 12'b0};
            corePkg::opAuipc:  return {w[31:12], 12'b0};
            corePkg::opJal:    return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            default:           return {{20{w[31]}}, w[31:20]};
        endcase
    endfunction

    function automatic corePkg::ctrlT ctrlOf(input logic [31:0] w);
        corePkg::ctrlT c;
        logic [6:0]    op;
        logic          known;
        op = w[6:0];
        known = op inside {corePkg::opLoad, corePkg::opStore, corePkg::opBranch,
                           corePkg::opJal, corePkg::opJalr, corePkg::opOpImm,
                           corePkg::opOp, corePkg::opLui, corePkg::opAuipc};
        c = '0;
        c.illegal   = !known;
        // Stores, branches and unknown opcodes write no register
        c.regWrite  = known && op != corePkg::opStore && op != corePkg::opBranch;
        c.memWrite  = op == corePkg::opStore;
        c.aluSrcImm = op inside {corePkg::opLoad, corePkg::opStore, corePkg::opOpImm};
        c.branch    = op == corePkg::opBranch;
        c.jump      = op inside {corePkg::opJal, corePkg::opJalr};
        c.jumpReg   = op == corePkg::opJalr;
        if (op == corePkg::opLoad) begin
            c.resultSrc = corePkg::resMem;
        end else if (c.jump) begin
            c.resultSrc = corePkg::resPc4;
        end
        return c;
    endfunction

    // JAL always, branch only backward
    function automatic logic takenOf(input logic [31:0] w);
        return w[6:0] == corePkg::opJal || (w[6:0] == corePkg::opBranch && w[31]);
    endfunction

    function automatic logic [31:0] nextPc(input logic [31:0] pc);
        return takenOf(wordAt(pc)) ? pc + immOf(wordAt(pc)) : pc + 32'd4;
    endfunction

    function automatic logic [31:0] encJal(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, corePkg::opJal};
    endfunction

    function automatic logic [31:0] encBranch(input logic [12:0] off, input logic [31:0] rnd);
        return {off[12], off[10:5], rnd[24:20], rnd[19:15], rnd[14:12], off[4:1], off[11],
                corePkg::opBranch};
    endfunction

    // Blocks of 16 words: 0 jumps to 5, 6 branches back to 2, 2 jumps to 7
    task automatic fillMemory();
        int          i;
        logic [31:0] rnd;
        logic [6:0]  op;
        for (i = 0; i < 256; i++) begin
            rnd = $urandom();
            case (rnd[2:0])
                3'd0: op = corePkg::opLoad;
                3'd1: op = corePkg::opStore;
                3'd2: op = corePkg::opOpImm;
                3'd3: op = corePkg::opOp;
                3'd4: op = corePkg::opLui;
                3'd5: op = corePkg::opAuipc;
                3'd6: op = corePkg::opJalr;
                default: op = corePkg::opBranch;
            endcase
            case (i % 16)
                0, 2: instrMem[i[7:0]] = encJal(21'd20, rnd[11:7]);
                6: instrMem[i[7:0]] = encBranch(13'h1ff0, rnd);
                // System and custom opcodes
                10: instrMem[i[7:0]] = {rnd[31:7], rnd[3] ? 7'b1110011 : 7'b1111111};
                12: instrMem[i[7:0]] = encBranch(13'd8, rnd);
                // Random branches kept forward
                default: instrMem[i[7:0]] = {(op == corePkg::opBranch) ? 1'b0 : rnd[31],
                                             rnd[30:7], op};
            endcase
        end
    endtask

    task automatic applyControls(input logic stall, input logic flushDec,
                                 input logic flushEx, input logic redirect,
                                 input logic [31:0] target);
        stallF        <= stall;
        stallD        <= stall;
        flushD        <= flushDec;
        flushE        <= flushEx;
        redirectValid <= redirect;
        redirectPc    <= target;
    endtask

    // Mode 0 free run, 1 stall bursts, 2 flush pulses, 3 redirects
    task automatic runTest(input string name, input int cycles, input int mode);
        int          errBefore;
        int          burstLeft;
        int          r;
        logic [31:0] rnd;
        errBefore = errorTotal();
        burstLeft = 0;
        repeat (cycles) begin
            @(posedge clk);
            r = $urandom_range(99);
            rnd = $urandom();
            if (mode == 1 && (burstLeft > 0 || r < 10)) begin
                // Hold fetch and decode, bubble into execute
                burstLeft = (burstLeft > 0) ? burstLeft - 1 : $urandom_range(3);
                applyControls(1'b1, 1'b0, 1'b1, 1'b0, '0);
            end else if (mode == 2 && r < 10) begin
                applyControls(1'b0, r < 5, r >= 5, 1'b0, '0);
            end else if (mode == 3 && r < 5) begin
                // Mispredict kills both younger slots
                applyControls(1'b0, 1'b1, 1'b1, 1'b1, {22'd0, rnd[7:0], 2'b00});
            end else begin
                applyControls(1'b0, 1'b0, 1'b0, 1'b0, '0);
            end
        end
        // Drain so late checks count here
        repeat (4) begin
            @(posedge clk);
            applyControls(1'b0, 1'b0, 1'b0, 1'b0, '0);
        end
        if (errorTotal() == errBefore) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errorTotal() - errBefore);
            failedTests++;
        end
    endtask

    // Shadow pipeline follows the stall, flush and redirect rules
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (!rstN) begin
            modelPc     <= corePkg::resetPc;
            modelDValid <= 1'b0;
            modelEValid <= 1'b0;
            modelDPc    <= '0;
            modelEPc    <= '0;
        end else begin
            modelEValid <= flushE ? 1'b0 : modelDValid;
            modelEPc    <= modelDPc;
            if (flushD) begin
                modelDValid <= 1'b0;
            end else if (!stallD) begin
                modelDValid <= 1'b1;
                modelDPc    <= modelPc;
            end
            if (redirectValid) begin
                modelPc <= redirectPc;
            end else if (!stallF) begin
                modelPc <= nextPc(modelPc);
            end
        end
    end

    flowOk: assert property (@(posedge clk) disable iff (!rstN)
        exPkt.valid == modelEValid && (!modelEValid || exPkt.pc == modelEPc))
        else begin
            errCount++;
            $error("Error at %0t: exPkt valid %b pc %h, expected valid %b pc %h", $time,
                   $sampled(exPkt.valid), $sampled(exPkt.pc), $sampled(modelEValid),
                   $sampled(modelEPc));
        end

    decodeOk: assert property (@(posedge clk) disable iff (!rstN)
        exPkt.valid |-> {exPkt.rd, exPkt.rs1, exPkt.rs2, exPkt.funct3, exPkt.funct7b5,
                         exPkt.op} == fieldsOf(wordAt(exPkt.pc))
                        && exPkt.imm == immOf(wordAt(exPkt.pc)))
        else begin
            errCount++;
            $error("Error at %0t: fields or imm %h wrong at pc %h", $time,
                   $sampled(exPkt.imm), $sampled(exPkt.pc));
        end

    ctrlOk: assert property (@(posedge clk) disable iff (!rstN)
        exPkt.valid |-> exPkt.ctrl == ctrlOf(wordAt(exPkt.pc)))
        else begin
            errCount++;
            $error("Error at %0t: ctrl %h wrong at pc %h", $time,
                   $sampled(exPkt.ctrl), $sampled(exPkt.pc));
        end

    predictOk: assert property (@(posedge clk) disable iff (!rstN)
        exPkt.valid |-> exPkt.predTaken == takenOf(wordAt(exPkt.pc))
                        && exPkt.predTarget == nextPc(exPkt.pc)
                        && exPkt.pcPlus4 == exPkt.pc + 32'd4)
        else begin
            errCount++;
            $error("Error at %0t: prediction %b to %h wrong at pc %h", $time,
                   $sampled(exPkt.predTaken), $sampled(exPkt.predTarget),
                   $sampled(exPkt.pc));
        end

    initial begin
        wait (cycleLimit > 0 && cycleCount >= cycleLimit);
        $display("Timeout: run did not finish within %0d cycles", cycleLimit);
        $display("tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'h71c9_ec3c));
        applyControls(1'b0, 1'b0, 1'b0, 1'b0, '0);
        failedTests = 0;
        // Four tests with drain, plus reset, and half again as margin
        cycleLimit = (4 * (320 + 4) + 8) * 3 / 2;
        fillMemory();
        wait (rstN);
        runTest("free run", 320, 0);
        runTest("stall bursts", 320, 1);
        runTest("flush pulses", 320, 2);
        runTest("redirects", 320, 3);
        $display("%0d of 4 tests with errors, %0d assertion errors", failedTests,
                 errorTotal());
        if (errorTotal() == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
rtl/corePkg.sv
rtl/pipeReg.sv
rtl/immExtend.sv
rtl/controlDecode.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/frontEnd.sv
verif/clockGen.sv
verif/frontEnd_props.sv
verif/frontEndTb.sv

//--- run.sh
#!/bin/sh
# Build and run the front-end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module frontEndTb -Mdir obj_dir -o frontEndSim -f project.f
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

# Keep running past assertion failures so the summary is printed
./obj_dir/frontEndSim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "all tests passed" sim.log; then
    exit 0
fi
echo "Pass line not found in sim.log"
exit 1
